// File: Makefile
TOP = sys_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sys_ctrl.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: bench/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
  output logic CLK,
  output logic RST
);

  localparam int HALF_PERIOD = 10;  // 20 ns period
  localparam int RST_CYCLES  = 10;

  initial
  begin
    CLK = 1'b0;
    forever
      #HALF_PERIOD CLK = ~CLK;
  end

  // release on a falling edge, clear of the sampling edge
  initial
  begin
    RST = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/sys_ctrl_chk.sv
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_chk (
  input logic CLK,
  input logic RST,
  input logic fifo_full,
  input logic fifo_winc,
  input logic gate_en,
  input logic alu_start,
  input logic alu_valid,
  input logic dec_rd_en,
  input logic dec_rd_valid,
  input logic alu_rd_en,
  input logic alu_rd_valid
);

  int         fail_cnt = 0;  // failed assertion count
  logic       job_open;      // start seen and valid still pending
  logic [4:0] job_cycles;    // cycles since start

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      job_open   <= 1'b0;
      job_cycles <= '0;
    end
    else if (alu_start)
    begin
      job_open   <= 1'b1;
      job_cycles <= '0;
    end
    else if (alu_valid)
      job_open <= 1'b0;
    else if (job_open)
      job_cycles <= job_cycles + 5'd1;
  end

  full_no_write: assert property (@(posedge CLK) disable iff (!RST) fifo_full |-> !fifo_winc)
  else
  begin
    $error("fifo_winc high while fifo_full is high");
    fail_cnt++;
  end

  // outputs quiet in the first cycle out of reset
  quiet_after_reset: assert property (@(posedge CLK) $rose(RST) |=> (!fifo_winc && !gate_en))
  else
  begin
    $error("fifo_winc or gate_en high one cycle after reset release");
    fail_cnt++;
  end

  // valid at most 12 cycles after start
  start_to_valid: assert property (@(posedge CLK) disable iff (!RST)
                                   job_open |-> (job_cycles < 5'd12))
  else
  begin
    $error("alu valid missing 12 cycles after start");
    fail_cnt++;
  end

  // each requester sees its rd_valid one cycle after its own rd_en
  dec_rd_to_valid: assert property (@(posedge CLK) disable iff (!RST)
                                    dec_rd_en |=> dec_rd_valid)
  else
  begin
    $error("decoder rd_valid missing one cycle after its rd_en");
    fail_cnt++;
  end

  alu_rd_to_valid: assert property (@(posedge CLK) disable iff (!RST)
                                    alu_rd_en |=> alu_rd_valid)
  else
  begin
    $error("alu rd_valid missing one cycle after its rd_en");
    fail_cnt++;
  end

  // response never steered to a requester that did not read
  dec_valid_owner: assert property (@(posedge CLK) disable iff (!RST)
                                    dec_rd_valid |-> $past(dec_rd_en))
  else
  begin
    $error("decoder rd_valid without its rd_en one cycle earlier");
    fail_cnt++;
  end

  alu_valid_owner: assert property (@(posedge CLK) disable iff (!RST)
                                    alu_rd_valid |-> $past(alu_rd_en))
  else
  begin
    $error("alu rd_valid without its rd_en one cycle earlier");
    fail_cnt++;
  end

endmodule

bind sys_ctrl_top sys_ctrl_chk i_chk (
  .CLK(CLK),
  .RST(RST),
  .fifo_full(fifo_full),
  .fifo_winc(fifo_winc),
  .gate_en(gate_en),
  .alu_start(alu_cmd.start),
  .alu_valid(alu_rsp.valid),
  .dec_rd_en(dec_req.rd_en),            // requester side of the arbiter
  .dec_rd_valid(dec_rsp.rd_valid),
  .alu_rd_en(alu_req.rd_en),
  .alu_rd_valid(alu_rsp_regf.rd_valid)
);

`default_nettype wire

// File: bench/sys_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_tb;

  localparam logic [7:0] WR_CMD  = 8'hAA;
  localparam logic [7:0] RD_CMD  = 8'hBB;
  localparam logic [7:0] OP_CMD  = 8'hCC;
  localparam logic [7:0] NOP_CMD = 8'hDD;
  localparam int DRAIN_TMO = 400;  // drain limit in cycles covering fifo_full stretches
  localparam int RST_TMO   = 40;

  logic       CLK;
  logic       RST;
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       fifo_full;
  logic [7:0] fifo_wdata;
  logic       fifo_winc;
  logic       gate_en;

  integer     seed = 32'h940c;
  logic       full_mode;          // random back-pressure on
  logic [7:0] model_mem [16];     // register file model
  logic [7:0] exp_q [$];          // bytes still due on the fifo
  logic [7:0] exp_byte;
  int         errors = 0;         // main sequence failures
  int         sink_errs = 0;      // fifo sink failures
  int         gate_cnt = 0;       // cycles with gate_en high
  int         test_num = 0;
  int         failed_tests = 0;
  int         test_start_errs;

  clk_gen i_clk_gen (.CLK(CLK), .RST(RST));

  sys_ctrl_top i_dut (
    .CLK(CLK), .RST(RST),
    .rx_data(rx_data), .rx_valid(rx_valid),
    .fifo_full(fifo_full), .fifo_wdata(fifo_wdata),
    .fifo_winc(fifo_winc), .gate_en(gate_en)
  );

  // fifo sink checks every write in order
  always @(posedge CLK)
  begin
    if (gate_en)
      gate_cnt = gate_cnt + 1;
    if (RST && fifo_winc)
    begin
      assert (exp_q.size() > 0)
      else
      begin
        $display("unexpected fifo write of %02h at %0t", fifo_wdata, $time);
        sink_errs = sink_errs + 1;
      end
      if (exp_q.size() > 0)
      begin
        exp_byte = exp_q.pop_front();
        assert (fifo_wdata == exp_byte)
        else
        begin
          $display("ERROR %0t fifo_wdata: expected %02h, got %02h", $time, exp_byte, fifo_wdata);
          sink_errs = sink_errs + 1;
        end
      end
    end
  end

  // alternating full and free stretches of random length
  initial
  begin
    int stretch;
    stretch   = 0;
    fifo_full = 1'b0;
    forever
    begin
      @(negedge CLK);
      if (!full_mode)
      begin
        fifo_full = 1'b0;
        stretch   = 0;
      end
      else if (stretch == 0)
      begin
        fifo_full = ~fifo_full;
        stretch   = $unsigned($random(seed)) % 8 + 1;
      end
      else
        stretch = stretch - 1;
    end
  end

  function automatic logic [15:0] alu_model(input logic [3:0] fun, input logic [7:0] a,
                                            input logic [7:0] b);
    logic [15:0] wa;
    logic [15:0] wb;
    wa = {8'h00, a};
    wb = {8'h00, b};
    case (fun)
      4'd0:    return wa + wb;
      4'd1:    return wa - wb;  // wraps mod 2^16
      4'd2:    return wa * wb;
      4'd3:    return wa & wb;
      4'd4:    return wa | wb;
      4'd5:    return wa ^ wb;
      4'd6:    return (a == b) ? 16'd1 : 16'd0;
      4'd7:    return wa >> 1;
      4'd8:    return wa << 1;
      default: return 16'd0;
    endcase
  endfunction

  function automatic int total_errs();
    return errors + sink_errs + i_dut.i_chk.fail_cnt;
  endfunction

  task automatic end_run();
    $display("tests: %0d, failed: %0d, errors: %0d", test_num, failed_tests, total_errs());
    if (total_errs() == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic begin_test();
    test_start_errs = total_errs();
    test_num        = test_num + 1;
  endtask

  task automatic end_test(input string name);
    if (total_errs() == test_start_errs)
      $display("test %0d %s: ok", test_num, name);
    else
    begin
      failed_tests = failed_tests + 1;
      $display("test %0d %s: failed, %0d errors", test_num, name, total_errs() - test_start_errs);
    end
  endtask

  // one frame after a random idle gap
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap + 1) @(negedge CLK);
    rx_data  = b;
    rx_valid = 1'b1;
    @(negedge CLK);
    rx_valid = 1'b0;
  endtask

  task automatic wait_reset();
    int cnt;
    cnt = 0;
    while (!RST && cnt < RST_TMO)
    begin
      @(negedge CLK);
      cnt = cnt + 1;
    end
    if (!RST)
    begin
      $display("reset was never released");
      errors = errors + 1;
    end
  endtask

  // all due bytes written and packer idle
  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while ((exp_q.size() != 0 || i_dut.tx_busy) && cnt < DRAIN_TMO)
    begin
      @(negedge CLK);
      cnt = cnt + 1;
    end
    if (exp_q.size() != 0 || i_dut.tx_busy)
    begin
      $display("timed out with %0d result bytes never written to the fifo", exp_q.size());
      errors = errors + 1;
      exp_q.delete();  // next command starts with nothing due
    end
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [7:0] data);
    send_byte(WR_CMD);
    send_byte({4'h0, addr});
    send_byte(data);
    model_mem[addr] = data;
  endtask

  task automatic reg_read(input logic [3:0] addr);
    exp_q.push_back(model_mem[addr]);
    send_byte(RD_CMD);
    send_byte({4'h0, addr});
    wait_drain();
  endtask

  // function frame with operands from the model at 0 and 1
  task automatic alu_fun(input logic [3:0] fun);
    logic [15:0] res;
    int          gate_before;
    res = alu_model(fun, model_mem[0], model_mem[1]);
    exp_q.push_back(res[7:0]);   // low byte first
    exp_q.push_back(res[15:8]);
    gate_before = gate_cnt;
    send_byte({4'h0, fun});
    wait_drain();
    assert (gate_cnt > gate_before)
    else
    begin
      $display("gate_en never went high during alu function %0d", fun);
      errors = errors + 1;
    end
  endtask

  task automatic alu_op(input logic [7:0] a, input logic [7:0] b, input logic [3:0] fun);
    model_mem[0] = a;
    model_mem[1] = b;
    send_byte(OP_CMD);
    send_byte(a);
    send_byte(b);
    alu_fun(fun);
  endtask

  task automatic alu_nop(input logic [3:0] fun);
    send_byte(NOP_CMD);
    alu_fun(fun);
  endtask

  initial
  begin
    logic [3:0] addr;
    logic [7:0] a;
    logic [7:0] b;
    rx_data   = 8'h00;
    rx_valid  = 1'b0;
    full_mode = 1'b0;
    model_mem = '{default: 8'h00};  // reset contents
    wait_reset();

    begin_test();
    repeat (20)
    begin
      @(posedge CLK);
      assert (!fifo_winc)
      else
      begin
        $display("ERROR %0t fifo_winc: expected 0, got %0b", $time, fifo_winc);
        errors = errors + 1;
      end
      assert (!gate_en)
      else
      begin
        $display("ERROR %0t gate_en: expected 0, got %0b", $time, gate_en);
        errors = errors + 1;
      end
    end
    end_test("idle after reset");

    begin_test();
    for (int i = 0; i < 6; i++)
    begin
      addr = 4'($random(seed));
      a    = 8'($random(seed));
      reg_write(addr, a);
      reg_read(addr);
    end
    end_test("register write and read");

    begin_test();
    for (int f = 0; f < 10; f++)  // code 9 unused and gives zero
    begin
      a = 8'($random(seed));
      b = 8'($random(seed));
      alu_op(a, b, 4'(f));
    end
    alu_op(8'h5C, 8'h5C, 4'd6);   // equal operands
    alu_op(8'hFF, 8'hFF, 4'd2);   // largest product
    end_test("alu command");

    begin_test();
    reg_write(4'd0, 8'($random(seed)));
    reg_write(4'd1, 8'($random(seed)));
    for (int f = 0; f < 9; f++)
      alu_nop(4'(f));
    end_test("alu reuse of held operands");

    begin_test();
    full_mode = 1'b1;
    for (int i = 0; i < 6; i++)
    begin
      addr = 4'($random(seed));
      reg_write(addr, 8'($random(seed)));
      reg_read(addr);
      alu_op(8'($random(seed)), 8'($random(seed)), 4'($unsigned($random(seed)) % 9));
    end
    full_mode = 1'b0;
    end_test("fifo back-pressure");

    begin_test();
    send_byte(8'h5A);   // none of these is a command
    send_byte(8'h12);
    send_byte(8'hFF);
    repeat (10) @(negedge CLK);  // sink flags any stray write
    for (int i = 0; i < 16; i++)
      reg_read(4'(i));
    end_test("unknown command byte");

    end_run();
  end

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
  input  logic                    CLK,
  input  logic                    RST,
  input  sys_ctrl_pkg::alu_cmd_t  cmd,
  output sys_ctrl_pkg::regf_req_t regf_req,
  input  sys_ctrl_pkg::regf_rsp_t regf_rsp,
  output sys_ctrl_pkg::alu_rsp_t  rsp
);

  logic                            rd_a_q;   // fetching operand a
  logic                            rd_b_q;   // fetching operand b
  sys_ctrl_pkg::alu_fun_e          fun_q;
  logic [sys_ctrl_pkg::DATA_W-1:0] opa_q;
  logic [sys_ctrl_pkg::RES_W-1:0]  a_ext;
  logic [sys_ctrl_pkg::RES_W-1:0]  b_ext;    // b straight from the read port
  logic [sys_ctrl_pkg::RES_W-1:0]  res_d;
  logic [sys_ctrl_pkg::RES_W-1:0]  res_q;
  logic                            valid_q;
  logic                            done;

  assign done = rd_b_q & regf_rsp.rd_valid;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      rd_a_q  <= 1'b0;
      rd_b_q  <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (cmd.start)
        rd_a_q <= 1'b1;
      else if (rd_a_q && regf_rsp.rd_valid)
        rd_a_q <= 1'b0;
      if (rd_a_q && regf_rsp.rd_valid)
        rd_b_q <= 1'b1;
      else if (done)
        rd_b_q <= 1'b0;
      valid_q <= done;  // single cycle pulse
    end
  end

  always_ff @(posedge CLK)
  begin
    if (cmd.start)
      fun_q <= cmd.fun;
    if (rd_a_q && regf_rsp.rd_valid)
      opa_q <= regf_rsp.rdata;
    if (done)
      res_q <= res_d;
  end

  // hold the read until its valid, drop it in the valid cycle so no second read
  assign regf_req.wr_en = 1'b0;
  assign regf_req.rd_en = (rd_a_q | rd_b_q) & ~regf_rsp.rd_valid;
  assign regf_req.addr  = rd_b_q ? sys_ctrl_pkg::OPB_ADDR : sys_ctrl_pkg::OPA_ADDR;
  assign regf_req.wdata = '0;

  assign a_ext = sys_ctrl_pkg::RES_W'(opa_q);
  assign b_ext = sys_ctrl_pkg::RES_W'(regf_rsp.rdata);

  always_comb
  begin
    case (fun_q)
      sys_ctrl_pkg::ALU_ADD: res_d = a_ext + b_ext;
      sys_ctrl_pkg::ALU_SUB: res_d = a_ext - b_ext;  // wraps mod 2^16
      sys_ctrl_pkg::ALU_MUL: res_d = a_ext * b_ext;
      sys_ctrl_pkg::ALU_AND: res_d = a_ext & b_ext;
      sys_ctrl_pkg::ALU_OR:  res_d = a_ext | b_ext;
      sys_ctrl_pkg::ALU_XOR: res_d = a_ext ^ b_ext;
      sys_ctrl_pkg::ALU_EQ:  res_d = sys_ctrl_pkg::RES_W'(a_ext == b_ext);
      sys_ctrl_pkg::ALU_SHR: res_d = a_ext >> 1;
      sys_ctrl_pkg::ALU_SHL: res_d = a_ext << 1;
      default:               res_d = '0;
    endcase
  end

  assign rsp = '{result: res_q, valid: valid_q};

endmodule

`default_nettype wire

// File: logic/frame_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module frame_decoder (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic [sys_ctrl_pkg::DATA_W-1:0] rx_data,
  input  logic                            rx_valid,
  output sys_ctrl_pkg::regf_req_t         regf_req,
  input  sys_ctrl_pkg::regf_rsp_t         regf_rsp,
  output sys_ctrl_pkg::alu_cmd_t          alu_cmd,
  input  sys_ctrl_pkg::alu_rsp_t          alu_rsp,
  output sys_ctrl_pkg::tx_req_t           tx_req,
  input  logic                            tx_busy,
  output logic                            gate_en
);

  sys_ctrl_pkg::dec_state_e state_q;
  sys_ctrl_pkg::dec_state_e state_d;

  logic [sys_ctrl_pkg::ADDR_W-1:0] addr_q;   // address frame latch
  logic                            load_q;
  logic [sys_ctrl_pkg::RES_W-1:0]  word_q;
  logic                            two_q;
  logic                            rd_cap;   // read byte captured
  logic                            alu_cap;  // alu result captured

  assign rd_cap  = (state_q == sys_ctrl_pkg::ST_RD_WAIT) && regf_rsp.rd_valid;
  assign alu_cap = (state_q == sys_ctrl_pkg::ST_ALU_WAIT) && alu_rsp.valid;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      state_q <= sys_ctrl_pkg::ST_IDLE;
      load_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      load_q  <= rd_cap | alu_cap;  // packer load one cycle after capture
    end
  end

  // latch and result holding, payload only
  always_ff @(posedge CLK)
  begin
    if (rx_valid && (state_q == sys_ctrl_pkg::ST_WR_ADDR ||
                     state_q == sys_ctrl_pkg::ST_RD_ADDR))
      addr_q <= rx_data[sys_ctrl_pkg::ADDR_W-1:0];  // upper nibble dropped
    if (rd_cap)
    begin
      word_q <= {{sys_ctrl_pkg::DATA_W{1'b0}}, regf_rsp.rdata};
      two_q  <= 1'b0;
    end
    else if (alu_cap)
    begin
      word_q <= alu_rsp.result;
      two_q  <= 1'b1;  // low byte then high byte
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      sys_ctrl_pkg::ST_IDLE:
      begin
        if (rx_valid)
        begin
          case (rx_data)
            sys_ctrl_pkg::CMD_REGF_WR: state_d = sys_ctrl_pkg::ST_WR_ADDR;
            sys_ctrl_pkg::CMD_REGF_RD: state_d = sys_ctrl_pkg::ST_RD_ADDR;
            sys_ctrl_pkg::CMD_ALU_OP:  state_d = sys_ctrl_pkg::ST_OPA;
            sys_ctrl_pkg::CMD_ALU_NOP: state_d = sys_ctrl_pkg::ST_FUN;  // reuse held operands
            default:                   state_d = sys_ctrl_pkg::ST_IDLE;  // unknown, ignore
          endcase
        end
      end
      sys_ctrl_pkg::ST_WR_ADDR:
        if (rx_valid) state_d = sys_ctrl_pkg::ST_WR_DATA;
      sys_ctrl_pkg::ST_WR_DATA:
        if (rx_valid) state_d = sys_ctrl_pkg::ST_IDLE;  // write happens on this edge
      sys_ctrl_pkg::ST_RD_ADDR:
        if (rx_valid) state_d = sys_ctrl_pkg::ST_RD_REQ;
      sys_ctrl_pkg::ST_RD_REQ:
        state_d = sys_ctrl_pkg::ST_RD_WAIT;
      sys_ctrl_pkg::ST_RD_WAIT:
        if (regf_rsp.rd_valid) state_d = sys_ctrl_pkg::ST_TX_WAIT;
      sys_ctrl_pkg::ST_OPA:
        if (rx_valid) state_d = sys_ctrl_pkg::ST_OPB;
      sys_ctrl_pkg::ST_OPB:
        if (rx_valid) state_d = sys_ctrl_pkg::ST_FUN;
      sys_ctrl_pkg::ST_FUN:
        if (rx_valid) state_d = sys_ctrl_pkg::ST_ALU_WAIT;
      sys_ctrl_pkg::ST_ALU_WAIT:
        if (alu_rsp.valid) state_d = sys_ctrl_pkg::ST_TX_WAIT;
      sys_ctrl_pkg::ST_TX_WAIT:
        // load still in flight means busy not yet up
        if (!tx_busy && !load_q) state_d = sys_ctrl_pkg::ST_IDLE;
      default:
        state_d = sys_ctrl_pkg::ST_IDLE;
    endcase
  end

  // register file port, only one request type per state
  always_comb
  begin
    regf_req = '0;
    case (state_q)
      sys_ctrl_pkg::ST_WR_DATA:
      begin
        regf_req.wr_en = rx_valid;
        regf_req.addr  = addr_q;
        regf_req.wdata = rx_data;
      end
      sys_ctrl_pkg::ST_RD_REQ:
      begin
        regf_req.rd_en = 1'b1;
        regf_req.addr  = addr_q;
      end
      sys_ctrl_pkg::ST_OPA:
      begin
        regf_req.wr_en = rx_valid;
        regf_req.addr  = sys_ctrl_pkg::OPA_ADDR;
        regf_req.wdata = rx_data;
      end
      sys_ctrl_pkg::ST_OPB:
      begin
        regf_req.wr_en = rx_valid;
        regf_req.addr  = sys_ctrl_pkg::OPB_ADDR;
        regf_req.wdata = rx_data;
      end
      default:
        regf_req = '0;
    endcase
  end

  assign alu_cmd.start = (state_q == sys_ctrl_pkg::ST_FUN) && rx_valid;
  assign alu_cmd.fun   = sys_ctrl_pkg::alu_fun_e'(rx_data[sys_ctrl_pkg::FUN_W-1:0]);

  // clock gate open from function frame until result capture
  assign gate_en = alu_cmd.start | (state_q == sys_ctrl_pkg::ST_ALU_WAIT);

  assign tx_req = '{load: load_q, word: word_q, two_bytes: two_q};

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic                    CLK,
  input  logic                    RST,
  input  sys_ctrl_pkg::regf_req_t req,
  output sys_ctrl_pkg::regf_rsp_t rsp
);

  localparam int DEPTH = 2 ** sys_ctrl_pkg::ADDR_W;

  logic [sys_ctrl_pkg::DATA_W-1:0] mem [DEPTH];
  logic [sys_ctrl_pkg::DATA_W-1:0] rdata_q;
  logic                            rd_valid_q;

  // storage, whole array cleared on reset
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
    end
    else if (req.wr_en)
      mem[req.addr] <= req.wdata;
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      rd_valid_q <= 1'b0;
    else
      rd_valid_q <= req.rd_en;  // exactly one cycle after rd_en
  end

  always_ff @(posedge CLK)
  begin
    if (req.rd_en)
      rdata_q <= mem[req.addr];
  end

  assign rsp = '{rdata: rdata_q, rd_valid: rd_valid_q};

endmodule

`default_nettype wire

// File: logic/regf_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module regf_arbiter (
  input  logic                    CLK,
  input  logic                    RST,
  input  sys_ctrl_pkg::regf_req_t dec_req,
  output sys_ctrl_pkg::regf_rsp_t dec_rsp,
  input  sys_ctrl_pkg::regf_req_t alu_req,
  output sys_ctrl_pkg::regf_rsp_t alu_rsp,
  output sys_ctrl_pkg::regf_req_t mem_req,
  input  sys_ctrl_pkg::regf_rsp_t mem_rsp
);

  logic dec_sel;    // decoder has priority
  logic alu_gnt_q;  // alu read granted last cycle

  assign dec_sel = dec_req.wr_en | dec_req.rd_en;

  // decoder never asks during an alu job, so fixed priority is enough
  assign mem_req = dec_sel ? dec_req : alu_req;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      alu_gnt_q <= 1'b0;
    else
      alu_gnt_q <= ~dec_sel & alu_req.rd_en;
  end

  // rdata shared, valid steered to the owner of the read
  always_comb
  begin
    dec_rsp          = mem_rsp;
    dec_rsp.rd_valid = mem_rsp.rd_valid & ~alu_gnt_q;
    alu_rsp          = mem_rsp;
    alu_rsp.rd_valid = mem_rsp.rd_valid & alu_gnt_q;
  end

endmodule

`default_nettype wire

// File: logic/sys_ctrl_pkg.sv
`default_nettype none

package sys_ctrl_pkg;

  localparam int DATA_W = 8;            // one uart byte
  localparam int ADDR_W = 4;            // 16 registers
  localparam int FUN_W  = 4;
  localparam int RES_W  = 2 * DATA_W;   // alu result, two bytes

  // command bytes, first frame of every command
  localparam logic [DATA_W-1:0] CMD_REGF_WR = 8'hAA;
  localparam logic [DATA_W-1:0] CMD_REGF_RD = 8'hBB;
  localparam logic [DATA_W-1:0] CMD_ALU_OP  = 8'hCC;
  localparam logic [DATA_W-1:0] CMD_ALU_NOP = 8'hDD;

  localparam logic [ADDR_W-1:0] OPA_ADDR = 4'd0;  // operand a lives here
  localparam logic [ADDR_W-1:0] OPB_ADDR = 4'd1;

  // unlisted codes give a zero result
  typedef enum logic [FUN_W-1:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_MUL = 4'd2,
    ALU_AND = 4'd3,
    ALU_OR  = 4'd4,
    ALU_XOR = 4'd5,
    ALU_EQ  = 4'd6,   // 1 when a == b
    ALU_SHR = 4'd7,   // a >> 1
    ALU_SHL = 4'd8    // a << 1
  } alu_fun_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_WR_ADDR,
    ST_WR_DATA,
    ST_RD_ADDR,
    ST_RD_REQ,     // rd_en out
    ST_RD_WAIT,    // wait rd_valid
    ST_OPA,
    ST_OPB,
    ST_FUN,
    ST_ALU_WAIT,
    ST_TX_WAIT     // packer draining
  } dec_state_e;

  typedef struct packed {
    logic              wr_en;
    logic              rd_en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } regf_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              rd_valid;
  } regf_rsp_t;

  typedef struct packed {
    logic     start;
    alu_fun_e fun;
  } alu_cmd_t;

  typedef struct packed {
    logic [RES_W-1:0] result;
    logic             valid;
  } alu_rsp_t;

  typedef struct packed {
    logic             load;
    logic [RES_W-1:0] word;
    logic             two_bytes;  // alu result, else single read byte
  } tx_req_t;

endpackage

`default_nettype wire

// File: logic/sys_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_top (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic [sys_ctrl_pkg::DATA_W-1:0] rx_data,
  input  logic                            rx_valid,
  input  logic                            fifo_full,
  output logic [sys_ctrl_pkg::DATA_W-1:0] fifo_wdata,
  output logic                            fifo_winc,
  output logic                            gate_en
);

  sys_ctrl_pkg::regf_req_t dec_req;
  sys_ctrl_pkg::regf_rsp_t dec_rsp;
  sys_ctrl_pkg::regf_req_t alu_req;       // reads only
  sys_ctrl_pkg::regf_rsp_t alu_rsp_regf;
  sys_ctrl_pkg::regf_req_t mem_req;
  sys_ctrl_pkg::regf_rsp_t mem_rsp;
  sys_ctrl_pkg::alu_cmd_t  alu_cmd;
  sys_ctrl_pkg::alu_rsp_t  alu_rsp;
  sys_ctrl_pkg::tx_req_t   tx_req;
  logic                    tx_busy;

  frame_decoder i_frame_decoder (
    .CLK(CLK), .RST(RST),
    .rx_data(rx_data), .rx_valid(rx_valid),
    .regf_req(dec_req), .regf_rsp(dec_rsp),
    .alu_cmd(alu_cmd), .alu_rsp(alu_rsp),
    .tx_req(tx_req), .tx_busy(tx_busy),
    .gate_en(gate_en)
  );

  regf_arbiter i_regf_arbiter (
    .CLK(CLK), .RST(RST),
    .dec_req(dec_req), .dec_rsp(dec_rsp),
    .alu_req(alu_req), .alu_rsp(alu_rsp_regf),
    .mem_req(mem_req), .mem_rsp(mem_rsp)
  );

  reg_file i_reg_file (.CLK(CLK), .RST(RST), .req(mem_req), .rsp(mem_rsp));

  alu_unit i_alu_unit (
    .CLK(CLK), .RST(RST), .cmd(alu_cmd),
    .regf_req(alu_req), .regf_rsp(alu_rsp_regf), .rsp(alu_rsp)
  );

  tx_byte_packer i_tx_byte_packer (
    .CLK(CLK), .RST(RST), .req(tx_req), .fifo_full(fifo_full),
    .fifo_wdata(fifo_wdata), .fifo_winc(fifo_winc), .busy(tx_busy)
  );

endmodule

`default_nettype wire

// File: logic/tx_byte_packer.sv
`timescale 1ns/100ps
`default_nettype none

module tx_byte_packer (
  input  logic                            CLK,
  input  logic                            RST,
  input  sys_ctrl_pkg::tx_req_t           req,
  input  logic                            fifo_full,
  output logic [sys_ctrl_pkg::DATA_W-1:0] fifo_wdata,
  output logic                            fifo_winc,
  output logic                            busy
);

  logic [sys_ctrl_pkg::RES_W-1:0] word_q;  // low byte always at the bottom
  logic [1:0]                     cnt_q;   // bytes left

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      cnt_q <= '0;
    else if (req.load)
      cnt_q <= req.two_bytes ? 2'd2 : 2'd1;
    else if (fifo_winc)
      cnt_q <= cnt_q - 2'd1;
  end

  always_ff @(posedge CLK)
  begin
    if (req.load)
      word_q <= req.word;
    else if (fifo_winc)
      word_q <= word_q >> sys_ctrl_pkg::DATA_W;  // high byte moves down
  end

  assign busy       = (cnt_q != 2'd0);
  assign fifo_winc  = busy & ~fifo_full;  // stall while full
  assign fifo_wdata = word_q[sys_ctrl_pkg::DATA_W-1:0];

endmodule

`default_nettype wire

// File: sys_ctrl.f
logic/sys_ctrl_pkg.sv
logic/frame_decoder.sv
logic/regf_arbiter.sv
logic/reg_file.sv
logic/alu_unit.sv
logic/tx_byte_packer.sv
logic/sys_ctrl_top.sv
bench/clk_gen.sv
bench/sys_ctrl_chk.sv
bench/sys_ctrl_tb.sv
